/* verilog.f */
hw/fft_pkg.sv
hw/fft_frame_loader.sv
hw/fft_butterfly.sv
hw/fft_frame_unloader.sv
hw/fft_core.sv
bench/tb_clock_gen.sv
bench/fft_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fft testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module fft_tb -f verilog.f -o fft_sim

# the simulator exits non-zero on a fatal check, tee keeps the script going to the log search
./obj_dir/fft_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "NO ERRORS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"

/* bench/fft_tb.sv */
`timescale 1ns/1ps
// fft testbench with impulse, constant, alternating and inverse frames checked by assertions
module fft_tb import fft_pkg::*; ();

	localparam int n_log2 = 4;
	localparam int n_points = 1 << n_log2;
	localparam int frame_gap = 20;
	localparam int n_frames = 4;
	// each frame run serially is gap plus pipeline latency plus unload, tripled for margin
	localparam int max_cycles = 3 * n_frames * (frame_gap + 3 * n_log2 + 2 + n_points);

	localparam int k_impulse = 0;
	localparam int k_const = 1;
	localparam int k_alt = 2;
	localparam int k_inv = 3;

	logic    clk;
	logic    rst_n;
	logic    inv;
	logic    stb;
	logic    sop_in;
	sample_t x_re;
	sample_t x_im;
	logic    valid_out;
	logic    sop_out;
	sample_t y_re;
	sample_t y_im;

	int seed;
	int cycle_cnt = 0;
	int frames_sent;
	int frame_kind [n_frames];
	int frame_amp [n_frames];

	// output frame tracking
	int   sop_count;
	int   ref_left;
	int   bin_idx;
	int   out_frame;
	int   exp_re;
	logic exp_valid;

	tb_clock_gen #(
		.period      (20),
		.reset_cycles(4)
	) u_clock_gen (
		.clk  (clk),
		.rst_n(rst_n)
	);

	fft_core #(
		.n_log2(n_log2)
	) u_fft_core (
		.clk      (clk),
		.rst_n    (rst_n),
		.inv      (inv),
		.stb      (stb),
		.sop_in   (sop_in),
		.x_re     (x_re),
		.x_im     (x_im),
		.valid_out(valid_out),
		.sop_out  (sop_out),
		.y_re     (y_re),
		.y_im     (y_im)
	);

	function automatic int stim_re(input int kind, input int amp, input int idx);
		int v;
		case (kind)
			k_impulse: v = (idx == 0) ? amp : 0;
			k_const:   v = amp;
			k_alt:     v = (idx == n_points / 2) ? amp : 0;
			default:   v = 0;
		endcase
		return v;
	endfunction

	function automatic int stim_im(input int kind, input int amp);
		return (kind == k_inv) ? amp : 0;
	endfunction

	// every test spectrum is purely real after the output mapping
	function automatic int expect_re(input int kind, input int amp, input int bin);
		int v;
		case (kind)
			k_impulse: v = amp;
			k_const:   v = (bin == 0) ? n_points * amp : 0;
			k_alt:     v = (bin % 2 == 0) ? amp : -amp;
			// swapped parts, 16C scaled back down by 1/N
			k_inv:     v = (bin == 0) ? amp : 0;
			default:   v = 0;
		endcase
		return v;
	endfunction

	function automatic int pick_amp(input int limit);
		int v;
		v = $random(seed) % limit;
		// zero would make the frame trivial
		if (v == 0) begin
			v = 1;
		end
		return v;
	endfunction

	task automatic report_value(input string name, input int got, input int want);
		$display("error at %0d ns: %s is %0d, expected %0d", $time, name, got, want);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("error at %0d ns: %s", $time, what);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			#2;
			stb    = 1'b0;
			sop_in = 1'b0;
			x_re   = sample_t'($random(seed));
			x_im   = sample_t'($random(seed));
		end
	endtask

	task automatic send_frame(input int kind, input int amp);
		frame_kind[frames_sent] = kind;
		frame_amp[frames_sent]  = amp;
		frames_sent++;
		for (int i = 0; i < n_points; i++) begin
			@(posedge clk);
			#2;
			stb    = 1'b1;
			sop_in = (i == 0);
			x_re   = sample_t'(stim_re(kind, amp, i));
			x_im   = sample_t'(stim_im(kind, amp));
		end
		idle(frame_gap - n_points);
	endtask

	task automatic wait_for_outputs(input int target);
		do begin
			@(posedge clk);
			#2;
		end while (sop_count != target || ref_left != 0 || valid_out);
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			report_failure($sformatf("timeout, run still busy after %0d cycles", max_cycles));
		end
	end

	// reference count of bins left in the current output frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sop_count <= 0;
			ref_left  <= 0;
		end else if (sop_out) begin
			sop_count <= sop_count + 1;
			ref_left  <= n_points - 1;
		end else if (ref_left != 0) begin
			ref_left <= ref_left - 1;
		end
	end

	always_comb begin
		exp_valid = sop_out || (ref_left != 0);
		bin_idx   = sop_out ? 0 : n_points - ref_left;
		out_frame = sop_out ? sop_count : sop_count - 1;
		exp_re    = 0;
		if (out_frame >= 0 && out_frame < n_frames) begin
			exp_re = expect_re(frame_kind[out_frame], frame_amp[out_frame], bin_idx);
		end
	end

	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !valid_out && !sop_out)
		else report_failure("valid_out or sop_out high while reset is asserted");

	a_valid_len: assert property (@(posedge clk) disable iff (!rst_n) valid_out == exp_valid)
		else report_value("valid_out", $sampled(valid_out), $sampled(exp_valid));

	a_one_sop: assert property (@(posedge clk) disable iff (!rst_n) sop_out |-> ref_left == 0)
		else report_failure("second sop_out inside one output frame");

	a_bin_re: assert property (@(posedge clk) disable iff (!rst_n)
		valid_out |-> int'(y_re) == exp_re)
		else report_value("y_re", $sampled(y_re), $sampled(exp_re));

	a_bin_im: assert property (@(posedge clk) disable iff (!rst_n) valid_out |-> y_im == 0)
		else report_value("y_im", $sampled(y_im), 0);

	initial begin
		seed        = 30603;
		inv         = 1'b0;
		stb         = 1'b0;
		sop_in      = 1'b0;
		x_re        = '0;
		x_im        = '0;
		frames_sent = 0;
		for (int i = 0; i < n_frames; i++) begin
			frame_kind[i] = 0;
			frame_amp[i]  = 0;
		end

		@(posedge rst_n);
		idle(2);

		// three frames back to back, all in flight together
		send_frame(k_impulse, pick_amp(8000));
		send_frame(k_const, pick_amp(2000));
		send_frame(k_alt, pick_amp(8000));
		wait_for_outputs(3);

		// inv acts at the unloader, so it changes between output frames
		inv = 1'b1;
		send_frame(k_inv, pick_amp(2000));
		wait_for_outputs(4);
		inv = 1'b0;
		idle(8);

		if (sop_count == n_frames) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			report_failure("number of output frames differs from frames sent");
		end
	end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
// bench clock and reset generator with a free-running clock and a held active-low reset
module tb_clock_gen #(
	parameter int period = 20,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2) clk = ~clk;
		end
	end

	// released just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

/* hw/fft_core.sv */
`timescale 1ns/1ps
// fft core: frame loader, parallel butterfly stage array and frame unloader
module fft_core import fft_pkg::*; #(
	parameter int n_log2 = 4
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    inv,
	input  logic    stb,
	input  logic    sop_in,
	input  sample_t x_re,
	input  sample_t x_im,
	output logic    valid_out,
	output logic    sop_out,
	output sample_t y_re,
	output sample_t y_im
);

	localparam int n_points = 1 << n_log2;
	localparam int n_units = n_points / 2;

	// st_*[m] feeds stage m, st_*[n_log2] holds the finished bins
	sample_t st_re [n_log2+1][n_points];
	sample_t st_im [n_log2+1][n_points];

	logic [n_log2:0]    st_valid;
	logic [n_units-1:0] unit_valid [n_log2];

	fft_frame_loader #(
		.n_log2(n_log2)
	) u_loader (
		.clk        (clk),
		.rst_n      (rst_n),
		.stb        (stb),
		.sop_in     (sop_in),
		.x_re       (x_re),
		.x_im       (x_im),
		.frame_re   (st_re[0]),
		.frame_im   (st_im[0]),
		.frame_start(st_valid[0])
	);

	// stage m pairs p with p + 2**m, twiddle W(2**(m+1))^j
	for (genvar m = 0; m < n_log2; m++) begin : g_stage
		for (genvar g = 0; g < (n_points >> (m + 1)); g++) begin : g_group
			for (genvar j = 0; j < (1 << m); j++) begin : g_unit
				localparam int p = (g << (m + 1)) + j;
				localparam int q = p + (1 << m);

				fft_butterfly #(
					.tw_index(j << (max_log2 - 1 - m)),
					.n_log2  (n_log2)
				) u_bfly (
					.clk  (clk),
					.rst_n(rst_n),
					.en   (st_valid[m]),
					.xp_re(st_re[m][p]),
					.xp_im(st_im[m][p]),
					.xq_re(st_re[m][q]),
					.xq_im(st_im[m][q]),
					.valid(unit_valid[m][(g << m) + j]),
					.yp_re(st_re[m+1][p]),
					.yp_im(st_im[m+1][p]),
					.yq_re(st_re[m+1][q]),
					.yq_im(st_im[m+1][q])
				);
			end
		end

		// units of a stage run in lockstep, unit 0 paces the next one
		assign st_valid[m+1] = unit_valid[m][0];
	end

	fft_frame_unloader #(
		.n_log2(n_log2)
	) u_unloader (
		.clk      (clk),
		.rst_n    (rst_n),
		.inv      (inv),
		.load     (st_valid[n_log2]),
		.bin_re   (st_re[n_log2]),
		.bin_im   (st_im[n_log2]),
		.valid_out(valid_out),
		.sop_out  (sop_out),
		.y_re     (y_re),
		.y_im     (y_im)
	);

endmodule

/* hw/fft_frame_unloader.sv */
`timescale 1ns/1ps
// frame unloader: output shift buffer, bin counter and inverse-mode mapping
module fft_frame_unloader import fft_pkg::*; #(
	parameter int n_log2 = 4,
	localparam int n_points = 1 << n_log2
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    inv,
	input  logic    load,
	input  sample_t bin_re [n_points],
	input  sample_t bin_im [n_points],
	output logic    valid_out,
	output logic    sop_out,
	output sample_t y_re,
	output sample_t y_im
);

	localparam logic [n_log2-1:0] last_bin = '1;

	sample_t sh_re [n_points];
	sample_t sh_im [n_points];

	logic [n_log2-1:0] cnt;

	// bin 0 always sits at the head of the buffer
	always_ff @(posedge clk) begin
		if (load) begin
			sh_re <= bin_re;
			sh_im <= bin_im;
		end else begin
			for (int k = 0; k < n_points - 1; k++) begin
				sh_re[k] <= sh_re[k+1];
				sh_im[k] <= sh_im[k+1];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_out <= 1'b0;
			sop_out   <= 1'b0;
			cnt       <= '0;
		end else begin
			sop_out <= load;
			if (load) begin
				valid_out <= 1'b1;
				cnt       <= '0;
			end else if (valid_out) begin
				cnt <= cnt + 1'b1;
				if (cnt == last_bin) begin
					valid_out <= 1'b0;
				end
			end
		end
	end

	// inverse via swapped parts, scaled by 1/N
	assign y_re = inv ? (sh_im[0] >>> n_log2) : sh_re[0];
	assign y_im = inv ? (sh_re[0] >>> n_log2) : sh_im[0];

	// a new frame may only land on the last bin of the one going out
	assert property (@(posedge clk) disable iff (!rst_n)
		load |-> (!valid_out || cnt == last_bin))
		else $error("fft_frame_unloader: load while bins are still being sent");

endmodule

/* hw/fft_butterfly.sv */
`timescale 1ns/1ps
// radix-2 DIT butterfly with a fixed twiddle, three register stages
module fft_butterfly import fft_pkg::*; #(
	parameter int tw_index = 0,
	parameter int n_log2 = 4
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    en,
	input  sample_t xp_re,
	input  sample_t xp_im,
	input  sample_t xq_re,
	input  sample_t xq_im,
	output logic    valid,
	output sample_t yp_re,
	output sample_t yp_im,
	output sample_t yq_re,
	output sample_t yq_im
);

	localparam sample_t w_re = tw_re[tw_index];
	localparam sample_t w_im = tw_im[tw_index];

	// twiddle must sit on the grid of an n_points transform
	if (n_log2 < 2 || n_log2 > max_log2) begin : g_bad_size
		$error("fft_butterfly: n_log2 %0d not supported", n_log2);
	end else if (tw_index % (1 << (max_log2 - n_log2)) != 0) begin : g_bad_twiddle
		$error("fft_butterfly: tw_index %0d off grid for n_log2 %0d", tw_index, n_log2);
	end

	logic [2:0] en_r;

	prod_t m_rr, m_ii, m_ri, m_ir;
	prod_t p1_re, p1_im;
	prod_t p2_re, p2_im;
	prod_t t_re, t_im;
	prod_t s_re, s_im, d_re, d_im;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_r <= '0;
		end else begin
			en_r <= {en_r[1:0], en};
		end
	end

	assign valid = en_r[2];

	always_ff @(posedge clk) begin
		// partial products, xp scaled up to the twiddle format
		if (en) begin
			m_rr  <= xq_re * w_re;
			m_ii  <= xq_im * w_im;
			m_ri  <= xq_re * w_im;
			m_ir  <= xq_im * w_re;
			p1_re <= prod_t'(xp_re) <<< tw_frac;
			p1_im <= prod_t'(xp_im) <<< tw_frac;
		end
		// xq times W
		if (en_r[0]) begin
			t_re  <= m_rr - m_ii;
			t_im  <= m_ri + m_ir;
			p2_re <= p1_re;
			p2_im <= p1_im;
		end
		if (en_r[1]) begin
			s_re <= p2_re + t_re;
			s_im <= p2_im + t_im;
			d_re <= p2_re - t_re;
			d_im <= p2_im - t_im;
		end
	end

	// drop the fraction, keep the sign
	assign yp_re = {s_re[31], s_re[tw_frac+data_w-2:tw_frac]};
	assign yp_im = {s_im[31], s_im[tw_frac+data_w-2:tw_frac]};
	assign yq_re = {d_re[31], d_re[tw_frac+data_w-2:tw_frac]};
	assign yq_im = {d_im[31], d_im[tw_frac+data_w-2:tw_frac]};

	// the previous stage spaces its frames wider than this pipeline
	assert property (@(posedge clk) disable iff (!rst_n) en |-> en_r == 3'b000)
		else $error("fft_butterfly: en while an earlier frame is in the pipeline");

endmodule

/* hw/fft_frame_loader.sv */
`timescale 1ns/1ps
// frame loader: input shift buffer and sample counter, frame out in bit-reversed order
module fft_frame_loader import fft_pkg::*; #(
	parameter int n_log2 = 4,
	localparam int n_points = 1 << n_log2
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    stb,
	input  logic    sop_in,
	input  sample_t x_re,
	input  sample_t x_im,
	output sample_t frame_re [n_points],
	output sample_t frame_im [n_points],
	output logic    frame_start
);

	localparam logic [n_log2-1:0] last_cnt = '1;

	sample_t sh_re [n_points];
	sample_t sh_im [n_points];

	logic              run;
	logic [n_log2-1:0] cnt;

	// newest sample enters at index 0, oldest drifts to the top
	always_ff @(posedge clk) begin
		if (stb) begin
			sh_re[0] <= x_re;
			sh_im[0] <= x_im;
			for (int k = 1; k < n_points; k++) begin
				sh_re[k] <= sh_re[k-1];
				sh_im[k] <= sh_im[k-1];
			end
		end
	end

	// samples strobed outside a frame are shifted in but not counted
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run         <= 1'b0;
			cnt         <= '0;
			frame_start <= 1'b0;
		end else begin
			frame_start <= 1'b0;
			if (stb && (run || sop_in)) begin
				// wraps back to zero on the last sample
				cnt <= cnt + 1'b1;
				if (cnt == last_cnt) begin
					run         <= 1'b0;
					frame_start <= 1'b1;
				end else begin
					run <= 1'b1;
				end
			end
		end
	end

	// oldest sample lands on index 0 of the stage array
	for (genvar i = 0; i < n_points; i++) begin : g_present
		assign frame_re[i] = sh_re[n_points - 1 - bit_reverse(i, n_log2)];
		assign frame_im[i] = sh_im[n_points - 1 - bit_reverse(i, n_log2)];
	end

	// a new frame may not cut into one still being counted
	assert property (@(posedge clk) disable iff (!rst_n) $rose(sop_in) |-> !run)
		else $error("fft_frame_loader: sop_in while a frame is still being counted");

endmodule

/* hw/fft_pkg.sv */
// fft package: sample formats, fixed-point twiddle constants and index helpers
package fft_pkg;

	// real or imaginary sample width
	localparam int data_w = 16;

	typedef logic signed [data_w-1:0] sample_t;

	// twiddle fraction bits, unity is 0x2000
	localparam int tw_frac = 13;

	// butterfly products and sums
	typedef logic signed [31:0] prod_t;

	// largest supported frame is 2**max_log2 points
	localparam int max_log2 = 6;
	localparam int tw_count = 1 << (max_log2 - 1);

	// W64^k for k = 0..31, real part
	localparam sample_t tw_re [tw_count] = '{
		16'sh2000, 16'sh1FD8, 16'sh1F62, 16'sh1E9F,
		16'sh1D90, 16'sh1C38, 16'sh1A9B, 16'sh18BC,
		16'sh16A0, 16'sh144C, 16'sh11C7, 16'sh0F15,
		16'sh0C3E, 16'sh094A, 16'sh063E, 16'sh0322,
		16'sh0000, 16'shFCDD, 16'shF9C1, 16'shF6B5,
		16'shF3C1, 16'shF0EA, 16'shEE38, 16'shEBB3,
		16'shE95F, 16'shE743, 16'shE564, 16'shE3C7,
		16'shE26F, 16'shE160, 16'shE09D, 16'shE027
	};

	// imaginary part, negative sine for the forward transform
	localparam sample_t tw_im [tw_count] = '{
		16'sh0000, 16'shFCDD, 16'shF9C1, 16'shF6B5,
		16'shF3C1, 16'shF0EA, 16'shEE38, 16'shEBB3,
		16'shE95F, 16'shE743, 16'shE564, 16'shE3C7,
		16'shE26F, 16'shE160, 16'shE09D, 16'shE027,
		16'shE000, 16'shE027, 16'shE09D, 16'shE160,
		16'shE26F, 16'shE3C7, 16'shE564, 16'shE743,
		16'shE95F, 16'shEBB3, 16'shEE38, 16'shF0EA,
		16'shF3C1, 16'shF6B5, 16'shF9C1, 16'shFCDD
	};

	// mirror the low bits of an index
	function automatic int unsigned bit_reverse(
		input int unsigned idx,
		input int unsigned bits
	);
		int unsigned res;
		res = 0;
		for (int b = 0; b < bits; b++) begin
			res = (res << 1) | ((idx >> b) & 1);
		end
		return res;
	endfunction

endpackage
